/* common/mem_settings.svh */
`ifndef MEM_SETTINGS_SVH
`define MEM_SETTINGS_SVH

// Processor side widths
`define ADDR_W      16
`define DATA_W      16

// Address split for the direct-mapped cache
// addr[15:8] index, addr[7:3] tag, addr[2:0] byte offset
`define TAG_W       5
`define INDEX_W     8
`define OFFSET_W    3

// Words in one cache line
`define LINE_WORDS  4

// Word address inside one of the four banks
`define BANK_ADDR_W 13

// Cycles a bank stays busy after it accepts an access
`define BANK_BUSY   4

`endif

/* common/cache_pkg.sv */
`include "mem_settings.svh"

package cache_pkg;

    ////////////////////////////////////////
    // Controller states
    ////////////////////////////////////////
    typedef enum logic [3:0] {
        IDLE       = 4'd0,
        COMPARE    = 4'd1,
        WRITEBACK  = 4'd2,
        WB_DRAIN   = 4'd3,
        FILL_REQ   = 4'd4,
        FILL_WAIT  = 4'd5,
        FILL_WRITE = 4'd6,
        FINISH     = 4'd7,
        REJECT     = 4'd8
    } ctrl_state_t;

    ////////////////////////////////////////
    // Cache-side fields
    ////////////////////////////////////////

    // Word inside a line, addr[2:1]
    typedef logic [1:0] word_sel_t;

    // Line tag, addr[7:3]
    typedef logic [`TAG_W-1:0] cache_tag_t;

    // Line number, addr[15:8]
    typedef logic [`INDEX_W-1:0] cache_index_t;

    // One data word as stored in a line
    typedef logic [`DATA_W-1:0] cache_word_t;

endpackage

/* common/mem_pkg.sv */
`include "mem_settings.svh"

package mem_pkg;

    // Operation the controller asks of main memory
    typedef enum logic [1:0] {
        MEM_IDLE  = 2'd0,
        MEM_READ  = 2'd1,
        MEM_WRITE = 2'd2
    } mem_op_t;

    // Bank number, word interleaved on addr[2:1]
    typedef logic [1:0] bank_sel_t;

    // Word address within one bank, addr[15:3]
    typedef logic [`BANK_ADDR_W-1:0] bank_addr_t;

endpackage

/* memory/mem_bank.sv */
`timescale 1ns/1ns
`include "mem_settings.svh"

module mem_bank (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 req,
    input  logic                 we,
    input  mem_pkg::bank_addr_t  word_addr,
    input  logic [`DATA_W-1:0]   wdata,
    output logic                 busy,
    output logic [`DATA_W-1:0]   rdata,
    output logic                 rvalid
);
    localparam int CNT_W = $clog2(`BANK_BUSY + 1);

    logic [`DATA_W-1:0] mem [1 << `BANK_ADDR_W];
    logic [CNT_W-1:0]   busy_cnt;
    logic               accept;
    logic               rd_stage;
    logic [`DATA_W-1:0] rd_data_stage;

    // Main memory powers up cleared
    initial begin
        for (int i = 0; i < (1 << `BANK_ADDR_W); i++) begin
            mem[i] = '0;
        end
    end

    assign busy   = (busy_cnt != '0);
    assign accept = req & ~busy;

    always_ff @(posedge clk) begin
        if (reset) begin
            busy_cnt <= '0;
        end else if (accept) begin
            busy_cnt <= CNT_W'(`BANK_BUSY);
        end else if (busy) begin
            busy_cnt <= busy_cnt - 1'b1;
        end
    end

    always @(posedge clk) begin
        if (accept && we) begin
            mem[word_addr] <= wdata;
        end
    end

    // Two-stage read return, data out two cycles after accept
    always_ff @(posedge clk) begin
        if (reset) begin
            rd_stage <= 1'b0;
            rvalid   <= 1'b0;
        end else begin
            rd_stage <= accept & ~we;
            rvalid   <= rd_stage;
        end
    end

    always_ff @(posedge clk) begin
        rd_data_stage <= mem[word_addr];
        rdata         <= rd_data_stage;
    end

endmodule

/* memory/four_bank_mem.sv */
`timescale 1ns/1ns
`include "mem_settings.svh"

module four_bank_mem (
    input  logic                clk,
    input  logic                reset,
    input  mem_pkg::mem_op_t    mem_op,
    input  logic [`ADDR_W-1:0]  mem_addr,
    input  logic [`DATA_W-1:0]  mem_wdata,
    output logic                mem_stall,
    output logic [`DATA_W-1:0]  mem_rdata
);
    import mem_pkg::*;

    localparam int NUM_BANKS = 4;

    bank_sel_t                bank_sel;
    bank_addr_t               bank_word;
    logic                     bank_we;
    logic [NUM_BANKS-1:0]     bank_req;
    logic [NUM_BANKS-1:0]     bank_busy;
    logic [NUM_BANKS-1:0]     bank_rvalid;
    logic [`DATA_W-1:0]       bank_rdata [NUM_BANKS];

    ////////////////////////////////////////
    // Address decode
    ////////////////////////////////////////
    assign bank_sel  = mem_addr[`OFFSET_W-1:1];
    assign bank_word = mem_addr[`ADDR_W-1:`OFFSET_W];
    assign bank_we   = (mem_op == MEM_WRITE);

    // Stall follows the bank under the current address
    assign mem_stall = bank_busy[bank_sel];

    for (genvar g = 0; g < NUM_BANKS; g++) begin : g_bank
        assign bank_req[g] = (mem_op != MEM_IDLE) && (bank_sel == bank_sel_t'(g));

        mem_bank i_bank (
            .clk       (clk),
            .reset     (reset),
            .req       (bank_req[g]),
            .we        (bank_we),
            .word_addr (bank_word),
            .wdata     (mem_wdata),
            .busy      (bank_busy[g]),
            .rdata     (bank_rdata[g]),
            .rvalid    (bank_rvalid[g])
        );
    end

    // At most one bank returns data in a cycle
    always_comb begin
        mem_rdata = '0;
        for (int i = 0; i < NUM_BANKS; i++) begin
            if (bank_rvalid[i]) begin
                mem_rdata = bank_rdata[i];
            end
        end
    end

endmodule

/* cache/cache_array.sv */
`timescale 1ns/1ns
`include "mem_settings.svh"

module cache_array (
    input  logic                    clk,
    input  logic                    reset,
    input  cache_pkg::cache_index_t index,
    input  cache_pkg::cache_tag_t   tag,
    input  cache_pkg::word_sel_t    word_sel,
    input  cache_pkg::cache_word_t  array_wdata,
    input  logic                    array_write,
    input  logic                    set_tag,
    input  logic                    mark_dirty,
    output logic                    hit,
    output logic                    valid,
    output logic                    dirty,
    output cache_pkg::cache_tag_t   victim_tag,
    output cache_pkg::cache_word_t  cache_rdata
);
    import cache_pkg::*;

    localparam int LINES = 1 << `INDEX_W;
    localparam int WORDS = LINES * `LINE_WORDS;

    cache_tag_t  tag_mem [LINES];
    cache_word_t data_mem [WORDS];
    logic [LINES-1:0] valid_bits;
    logic [LINES-1:0] dirty_bits;
    logic [`INDEX_W+1:0] word_addr;

    // Flat word address, line number above word in line
    assign word_addr = {index, word_sel};

    ////////////////////////////////////////
    // Combinational lookup
    ////////////////////////////////////////
    assign valid       = valid_bits[index];
    assign dirty       = dirty_bits[index];
    assign victim_tag  = tag_mem[index];
    assign hit         = valid_bits[index] & (tag_mem[index] == tag);
    assign cache_rdata = data_mem[word_addr];

    ////////////////////////////////////////
    // Storage updates
    ////////////////////////////////////////

    // Line status bits
    always_ff @(posedge clk) begin
        if (reset) begin
            valid_bits <= '0;
            dirty_bits <= '0;
        end else if (set_tag) begin
            valid_bits[index] <= 1'b1;
            // Fresh line is clean unless a write lands with it
            dirty_bits[index] <= mark_dirty;
        end else if (mark_dirty) begin
            dirty_bits[index] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (set_tag) begin
            tag_mem[index] <= tag;
        end
    end

    always_ff @(posedge clk) begin
        if (array_write) begin
            data_mem[word_addr] <= array_wdata;
        end
    end

endmodule

/* cache/cache_ctrl.sv */
`timescale 1ns/1ns
`include "mem_settings.svh"

module cache_ctrl (
    input  logic                    clk,
    input  logic                    reset,
    input  logic [`ADDR_W-1:0]      addr,
    input  logic [`DATA_W-1:0]      data_in,
    input  logic                    rd,
    input  logic                    wr,
    input  logic                    hit,
    input  logic                    valid,
    input  logic                    dirty,
    input  cache_pkg::cache_tag_t   victim_tag,
    input  cache_pkg::cache_word_t  cache_rdata,
    input  logic                    mem_stall,
    input  logic [`DATA_W-1:0]      mem_rdata,
    output logic [`DATA_W-1:0]      data_out,
    output logic                    done,
    output logic                    cache_hit,
    output logic                    err,
    output logic                    stall,
    output cache_pkg::cache_index_t index,
    output cache_pkg::cache_tag_t   tag,
    output cache_pkg::word_sel_t    word_sel,
    output cache_pkg::cache_word_t  array_wdata,
    output logic                    array_write,
    output logic                    set_tag,
    output logic                    mark_dirty,
    output mem_pkg::mem_op_t        mem_op,
    output logic [`ADDR_W-1:0]      mem_addr,
    output logic [`DATA_W-1:0]      mem_wdata
);
    import cache_pkg::*;
    import mem_pkg::*;

    ctrl_state_t state;
    ctrl_state_t next_state;
    word_sel_t   word_cnt;
    word_sel_t   req_word;
    logic        hit_q;
    cache_word_t data_q;
    logic        bad_req;
    logic        last_word;
    logic        write_hit;

    ////////////////////////////////////////
    // Request fields
    ////////////////////////////////////////
    assign index     = addr[`ADDR_W-1 -: `INDEX_W];
    assign tag       = addr[`OFFSET_W +: `TAG_W];
    assign req_word  = addr[`OFFSET_W-1:1];
    // Odd byte address or both strobes at once
    assign bad_req   = (rd & wr) | addr[0];
    assign last_word = (word_cnt == word_sel_t'(`LINE_WORDS - 1));
    assign write_hit = (state == COMPARE) & hit & wr;

    ////////////////////////////////////////
    // Next state
    ////////////////////////////////////////
    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                if (rd | wr) begin
                    next_state = bad_req ? REJECT : COMPARE;
                end
            end
            COMPARE: begin
                if (hit) begin
                    next_state = FINISH;
                end else if (valid & dirty) begin
                    next_state = WRITEBACK;
                end else begin
                    next_state = FILL_REQ;
                end
            end
            WRITEBACK: begin
                if (!mem_stall && last_word) begin
                    next_state = WB_DRAIN;
                end
            end
            // Wait for the bank of the first fill word
            WB_DRAIN: begin
                if (!mem_stall) begin
                    next_state = FILL_REQ;
                end
            end
            FILL_REQ: begin
                if (!mem_stall) begin
                    next_state = FILL_WAIT;
                end
            end
            FILL_WAIT:  next_state = FILL_WRITE;
            FILL_WRITE: next_state = last_word ? FINISH : FILL_REQ;
            FINISH:     next_state = IDLE;
            REJECT:     next_state = IDLE;
            default:    next_state = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    // Word counter walks the line during writeback and fill
    always_ff @(posedge clk) begin
        if (reset) begin
            word_cnt <= '0;
        end else if (state == IDLE) begin
            word_cnt <= '0;
        end else if ((state == WRITEBACK && !mem_stall) || state == FILL_WRITE) begin
            word_cnt <= word_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            hit_q <= 1'b0;
        end else if (state == IDLE) begin
            hit_q <= 1'b0;
        end else if (state == COMPARE) begin
            hit_q <= hit;
        end
    end

    // Requested word, from the array on a hit or from the fill
    always_ff @(posedge clk) begin
        if (state == COMPARE && hit) begin
            data_q <= rd ? cache_rdata : data_in;
        end else if (state == FILL_WRITE && word_cnt == req_word) begin
            data_q <= array_wdata;
        end
    end

    ////////////////////////////////////////
    // Cache array side
    ////////////////////////////////////////
    always_comb begin
        case (state)
            WRITEBACK, FILL_WRITE: word_sel = word_cnt;
            default:               word_sel = req_word;
        endcase
    end

    // Write miss merges its word into the incoming line
    assign array_wdata = (state == FILL_WRITE && !(wr && word_cnt == req_word)) ?
                         mem_rdata : data_in;
    assign array_write = write_hit | (state == FILL_WRITE);
    assign set_tag     = (state == FILL_WRITE) & last_word;
    assign mark_dirty  = write_hit | ((state == FILL_WRITE) & last_word & wr);

    ////////////////////////////////////////
    // Memory side
    ////////////////////////////////////////
    always_comb begin
        case (state)
            WRITEBACK: mem_op = MEM_WRITE;
            FILL_REQ:  mem_op = MEM_READ;
            default:   mem_op = MEM_IDLE;
        endcase
    end

    // Victim line goes back under its stored tag
    assign mem_addr  = (state == WRITEBACK) ? {index, victim_tag, word_cnt, 1'b0} :
                                              {index, tag, word_cnt, 1'b0};
    assign mem_wdata = cache_rdata;

    ////////////////////////////////////////
    // Processor side
    ////////////////////////////////////////
    assign data_out  = data_q;
    assign done      = (state == FINISH) | (state == REJECT);
    assign err       = (state == REJECT);
    assign cache_hit = (state == FINISH) & hit_q;
    assign stall     = (state == WRITEBACK) | (state == WB_DRAIN) | (state == FILL_REQ) |
                       (state == FILL_WAIT) | (state == FILL_WRITE);

endmodule

/* hdl/mem_system.sv */
`timescale 1ns/1ns
`include "mem_settings.svh"

module mem_system (
    input  logic               clk,
    input  logic               reset,
    input  logic [`ADDR_W-1:0] addr,
    input  logic [`DATA_W-1:0] data_in,
    input  logic               rd,
    input  logic               wr,
    output logic [`DATA_W-1:0] data_out,
    output logic               done,
    output logic               stall,
    output logic               cache_hit,
    output logic               err
);
    import cache_pkg::*;
    import mem_pkg::*;

    // Controller to cache array
    cache_index_t index;
    cache_tag_t   tag;
    word_sel_t    word_sel;
    cache_word_t  array_wdata;
    logic         array_write;
    logic         set_tag;
    logic         mark_dirty;

    // Cache array to controller
    logic         hit;
    logic         valid;
    logic         dirty;
    cache_tag_t   victim_tag;
    cache_word_t  cache_rdata;

    // Controller and main memory
    mem_op_t             mem_op;
    logic [`ADDR_W-1:0]  mem_addr;
    logic [`DATA_W-1:0]  mem_wdata;
    logic                mem_stall;
    logic [`DATA_W-1:0]  mem_rdata;

    cache_ctrl i_ctrl (
        .clk         (clk),
        .reset       (reset),
        .addr        (addr),
        .data_in     (data_in),
        .rd          (rd),
        .wr          (wr),
        .hit         (hit),
        .valid       (valid),
        .dirty       (dirty),
        .victim_tag  (victim_tag),
        .cache_rdata (cache_rdata),
        .mem_stall   (mem_stall),
        .mem_rdata   (mem_rdata),
        .data_out    (data_out),
        .done        (done),
        .cache_hit   (cache_hit),
        .err         (err),
        .stall       (stall),
        .index       (index),
        .tag         (tag),
        .word_sel    (word_sel),
        .array_wdata (array_wdata),
        .array_write (array_write),
        .set_tag     (set_tag),
        .mark_dirty  (mark_dirty),
        .mem_op      (mem_op),
        .mem_addr    (mem_addr),
        .mem_wdata   (mem_wdata)
    );

    cache_array i_cache (
        .clk         (clk),
        .reset       (reset),
        .index       (index),
        .tag         (tag),
        .word_sel    (word_sel),
        .array_wdata (array_wdata),
        .array_write (array_write),
        .set_tag     (set_tag),
        .mark_dirty  (mark_dirty),
        .hit         (hit),
        .valid       (valid),
        .dirty       (dirty),
        .victim_tag  (victim_tag),
        .cache_rdata (cache_rdata)
    );

    four_bank_mem i_mem (
        .clk       (clk),
        .reset     (reset),
        .mem_op    (mem_op),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_stall (mem_stall),
        .mem_rdata (mem_rdata)
    );

endmodule

/* testbench/tb_mem_system.sv */
`timescale 1ns/1ns
`include "mem_settings.svh"

module tb_mem_system;

    localparam int CLK_PERIOD     = 40;
    localparam int RESET_CYCLES   = 10;
    localparam int RANDOM_COUNT   = 300;
    localparam int DIRECTED_COUNT = 16;
    // Worst miss covers writeback, bank drain and four fills with bank waits
    localparam int MISS_CYCLES    = 32;
    localparam int HIT_LATENCY    = 2;
    localparam int ERR_LATENCY    = 1;
    localparam int WATCHDOG_CYCLES =
        2 * (RESET_CYCLES + (RANDOM_COUNT + DIRECTED_COUNT) * (MISS_CYCLES + 2));
    localparam int MEM_WORDS      = 1 << (`ADDR_W - 1);
    localparam int LINES          = 1 << `INDEX_W;

    logic               clk;
    logic               reset;
    logic [`ADDR_W-1:0] addr;
    logic [`DATA_W-1:0] data_in;
    logic               rd;
    logic               wr;
    logic [`DATA_W-1:0] data_out;
    logic               done;
    logic               stall;
    logic               cache_hit;
    logic               err;

    // Reference state
    logic [`DATA_W-1:0] shadow_mem [MEM_WORDS];
    logic [`TAG_W-1:0]  shadow_tag [LINES];
    logic [LINES-1:0]   shadow_valid;

    // One expected entry per request in flight
    string              name_q [$];
    logic               exp_err_q [$];
    logic               exp_hit_q [$];
    logic [`DATA_W-1:0] exp_data_q [$];

    int                 mismatch_count = 0;
    int                 other_count = 0;
    int                 cycle_cnt = 0;
    int                 issue_cycle = 0;
    int                 latency;
    logic               stall_seen = 1'b0;
    logic               reset_checked = 1'b0;
    string              cur_name;
    logic               cur_err;
    logic               cur_hit;
    logic [`DATA_W-1:0] cur_data;

    logic [31:0]         rand_state;
    logic [`INDEX_W-1:0] r_line;
    logic [`TAG_W-1:0]   r_tag;
    logic [1:0]          r_word;
    logic                r_write;
    logic [`DATA_W-1:0]  r_data;

    mem_system i_dut (
        .clk       (clk),
        .reset     (reset),
        .addr      (addr),
        .data_in   (data_in),
        .rd        (rd),
        .wr        (wr),
        .data_out  (data_out),
        .done      (done),
        .stall     (stall),
        .cache_hit (cache_hit),
        .err       (err)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    ////////////////////////////////////////
    // Helpers and reference model
    ////////////////////////////////////////
    function automatic logic [31:0] lcg_step(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [`ADDR_W-1:0] make_addr(input logic [`INDEX_W-1:0] line_idx,
                                                     input logic [`TAG_W-1:0] line_tag,
                                                     input logic [1:0] word);
        return {line_idx, line_tag, word, 1'b0};
    endfunction

    // Result packed as {err, cache_hit, data_out}
    function automatic logic [`DATA_W+1:0] predict(input logic [`ADDR_W-1:0] a,
                                                   input logic [`DATA_W-1:0] d,
                                                   input logic r,
                                                   input logic w);
        logic [`INDEX_W-1:0] line_idx;
        logic [`TAG_W-1:0]   line_tag;
        logic [`ADDR_W-2:0]  word_addr;
        logic                exp_hit;
        logic [`DATA_W-1:0]  exp_data;
        // Rejected requests touch nothing
        if ((r && w) || a[0]) begin
            return {1'b1, 1'b0, {`DATA_W{1'b0}}};
        end
        line_idx  = a[`ADDR_W-1 -: `INDEX_W];
        line_tag  = a[`OFFSET_W +: `TAG_W];
        word_addr = a[`ADDR_W-1:1];
        exp_hit   = shadow_valid[line_idx] && (shadow_tag[line_idx] == line_tag);
        // Every access allocates, reads and writes alike
        shadow_valid[line_idx] = 1'b1;
        shadow_tag[line_idx]   = line_tag;
        if (w) begin
            shadow_mem[word_addr] = d;
            exp_data = d;
        end else begin
            exp_data = shadow_mem[word_addr];
        end
        return {1'b0, exp_hit, exp_data};
    endfunction

    task automatic compare_value(input string test_name,
                                 input logic [31:0] expected,
                                 input logic [31:0] actual);
        if (expected !== actual) begin
            $display("Mismatch %s: expected %0h, actual %0h", test_name, expected, actual);
            mismatch_count++;
        end
    endtask

    task automatic issue_request(input string test_name,
                                 input logic [`ADDR_W-1:0] a,
                                 input logic [`DATA_W-1:0] d,
                                 input logic r,
                                 input logic w);
        logic [`DATA_W+1:0] expected;
        @(posedge clk);
        expected = predict(a, d, r, w);
        name_q.push_back(test_name);
        exp_err_q.push_back(expected[`DATA_W+1]);
        exp_hit_q.push_back(expected[`DATA_W]);
        exp_data_q.push_back(expected[`DATA_W-1:0]);
        // First cycle in which the DUT sees the request
        issue_cycle = cycle_cnt + 1;
        addr    <= a;
        data_in <= d;
        rd      <= r;
        wr      <= w;
        @(negedge clk);
        while (!done) begin
            @(negedge clk);
        end
        // Strobes fall in the cycle after done
        @(posedge clk);
        rd <= 1'b0;
        wr <= 1'b0;
    endtask

    ////////////////////////////////////////
    // Compare process
    ////////////////////////////////////////
    always @(negedge clk) begin
        if (stall) begin
            stall_seen = 1'b1;
        end
        if (!reset && !reset_checked) begin
            compare_value("reset done", 32'd0, 32'(done));
            compare_value("reset err", 32'd0, 32'(err));
            compare_value("reset cache_hit", 32'd0, 32'(cache_hit));
            compare_value("reset stall", 32'd0, 32'(stall));
            reset_checked = 1'b1;
        end
        if (!reset && done) begin
            if (name_q.size() == 0) begin
                $display("Done pulsed while no request was pending");
                other_count++;
            end else begin
                cur_name = name_q.pop_front();
                cur_err  = exp_err_q.pop_front();
                cur_hit  = exp_hit_q.pop_front();
                cur_data = exp_data_q.pop_front();
                latency  = cycle_cnt - issue_cycle;
                compare_value({cur_name, " err"}, 32'(cur_err), 32'(err));
                compare_value({cur_name, " cache_hit"}, 32'(cur_hit), 32'(cache_hit));
                // Only a miss goes out to main memory
                compare_value({cur_name, " stall"}, 32'(!cur_err && !cur_hit), 32'(stall_seen));
                if (cur_err) begin
                    compare_value({cur_name, " latency"}, 32'(ERR_LATENCY), 32'(latency));
                end else begin
                    compare_value({cur_name, " data_out"}, 32'(cur_data), 32'(data_out));
                    if (cur_hit) begin
                        compare_value({cur_name, " latency"}, 32'(HIT_LATENCY), 32'(latency));
                    end else if (latency <= HIT_LATENCY) begin
                        $display("%s finished a miss in %0d cycles, no slower than a hit",
                                 cur_name, latency);
                        other_count++;
                    end
                end
            end
            stall_seen = 1'b0;
        end
    end

    ////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////
    initial begin
        clk        = 1'b0;
        reset      = 1'b1;
        addr       = '0;
        data_in    = '0;
        rd         = 1'b0;
        wr         = 1'b0;
        rand_state = 32'ha2dc;
        for (int i = 0; i < MEM_WORDS; i++) begin
            shadow_mem[i] = '0;
        end
        for (int i = 0; i < LINES; i++) begin
            shadow_tag[i] = '0;
        end
        shadow_valid = '0;

        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);

        // Cold read and a repeat of the same word
        issue_request("cold read", make_addr(8'h10, 5'h03, 2'd2), 16'h0000, 1'b1, 1'b0);
        issue_request("repeat read", make_addr(8'h10, 5'h03, 2'd2), 16'h0000, 1'b1, 1'b0);

        // Write miss allocates the whole line
        issue_request("write miss", make_addr(8'h20, 5'h05, 2'd1), 16'hbeef, 1'b0, 1'b1);
        for (int w = 0; w < `LINE_WORDS; w++) begin
            issue_request($sformatf("line read %0d", w),
                          make_addr(8'h20, 5'h05, 2'(w)), 16'h0000, 1'b1, 1'b0);
        end

        // Dirty victim goes back to memory
        issue_request("dirty write", make_addr(8'h30, 5'h01, 2'd3), 16'h1234, 1'b0, 1'b1);
        issue_request("evict read", make_addr(8'h30, 5'h02, 2'd3), 16'h0000, 1'b1, 1'b0);
        issue_request("refetch read", make_addr(8'h30, 5'h01, 2'd3), 16'h0000, 1'b1, 1'b0);

        // Bad requests
        issue_request("odd read", make_addr(8'h10, 5'h03, 2'd2) | 16'h0001, 16'h0000,
                      1'b1, 1'b0);
        issue_request("odd write", make_addr(8'h30, 5'h01, 2'd3) | 16'h0001, 16'hffff,
                      1'b0, 1'b1);
        issue_request("rd and wr", make_addr(8'h10, 5'h03, 2'd2), 16'hdead, 1'b1, 1'b1);
        issue_request("read after err", make_addr(8'h10, 5'h03, 2'd2), 16'h0000, 1'b1, 1'b0);
        issue_request("read after odd write", make_addr(8'h30, 5'h01, 2'd3), 16'h0000,
                      1'b1, 1'b0);

        // Few lines and few tags so lines keep evicting each other
        for (int i = 0; i < RANDOM_COUNT; i++) begin
            rand_state = lcg_step(rand_state);
            r_line  = {6'b010000, rand_state[17:16]};
            r_tag   = {3'b000, rand_state[19:18]};
            r_word  = rand_state[21:20];
            r_write = rand_state[22];
            rand_state = lcg_step(rand_state);
            r_data  = rand_state[31:16];
            issue_request($sformatf("random %0d", i), make_addr(r_line, r_tag, r_word),
                          r_data, !r_write, r_write);
        end

        repeat (4) @(posedge clk);
        $display("Error count: %0d mismatches, %0d other errors", mismatch_count, other_count);
        if (mismatch_count + other_count == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Timeout: the run did not complete within %0d cycles", WATCHDOG_CYCLES);
        $display("Error count: %0d mismatches, %0d other errors", mismatch_count, other_count);
        $display("Errors found");
        $finish;
    end

endmodule

/* filelist.f */
+incdir+common
common/cache_pkg.sv
common/mem_pkg.sv
memory/mem_bank.sv
memory/four_bank_mem.sv
cache/cache_array.sv
cache/cache_ctrl.sv
hdl/mem_system.sv
testbench/tb_mem_system.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    := --sv --timing
TOP       := tb_mem_system
FILELIST  := filelist.f
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := No errors

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		-Mdir $(OBJ_DIR) -o V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
